/* include/decode_defs.svh */
// Widths, queue sizing and instruction encodings for the decode stage
// Include wherever a width, opcode or function code is needed

`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Issue group
`define DEC_ISSUE_WIDTH    2
`define DEC_P_ISSUE_WIDTH  1

`define DEC_INSN_W         32
`define DEC_DW             32
`define DEC_PC_W           32
`define DEC_LRF_AW         5

// Fetch queue
`define DEC_FQ_DEPTH       8
`define DEC_FQ_AW          3

// Opcodes, bits 31:26
`define DEC_OPC_ALU        6'h00
`define DEC_OPC_ADDI       6'h01
`define DEC_OPC_ANDI       6'h02
`define DEC_OPC_LW         6'h10
`define DEC_OPC_SW         6'h11
`define DEC_OPC_BEQ        6'h20
`define DEC_OPC_JAL        6'h21

// R-type function codes, bits 5:0
`define DEC_FN_ADD         6'd0
`define DEC_FN_SUB         6'd1
`define DEC_FN_AND         6'd2
`define DEC_FN_OR          6'd3
`define DEC_FN_XOR         6'd4

`endif

/* source/decode_pkg.sv */
// Micro-op types shared by the decoder, the decode stage and the top level
// Import with decode_pkg::* in the module header

`include "decode_defs.svh"

package decode_pkg;

   // Operation class, one value per execution behaviour
   typedef enum logic [3:0]
   {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_LOAD,
      OP_STORE,
      OP_BEQ,
      OP_JAL,
      OP_ILLEGAL,
      OP_IRQ
   } uop_op_t;

   // Decoded instruction as handed to rename
   typedef struct packed
   {
      uop_op_t                   op;
      logic [`DEC_DW-1:0]        imm;
      logic [`DEC_LRF_AW-1:0]    lrs1;
      logic                      lrs1_re;
      logic [`DEC_LRF_AW-1:0]    lrs2;
      logic                      lrs2_re;
      logic [`DEC_LRF_AW-1:0]    lrd;
      logic                      lrd_we;
   } uop_t;

endpackage

/* source/fetch_if.sv */
// Fetch queue to decode stage connection
// Lane 0 carries the oldest entry, valid lanes are contiguous from lane 0

`timescale 1ns/100ps

`include "decode_defs.svh"

interface fetch_if;

   logic [`DEC_ISSUE_WIDTH-1:0]                  valid;
   logic [`DEC_ISSUE_WIDTH-1:0][`DEC_INSN_W-1:0] ins;
   logic [`DEC_ISSUE_WIDTH-1:0][`DEC_PC_W-1:0]   pc;
   // Entries consumed at the next edge
   logic [`DEC_P_ISSUE_WIDTH:0]                  pop_cnt;

   modport queue
   (
      output valid, ins, pc,
      input  pop_cnt
   );

   modport dec
   (
      input  valid, ins, pc,
      output pop_cnt
   );

endinterface

/* source/fetch_queue.sv */
// Circular instruction queue feeding the decode stage
// Presents its oldest entries per lane and retires pop_cnt of them each edge

`timescale 1ns/100ps

`include "decode_defs.svh"

module fetch_queue
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   flush,
   input  logic                   push_valid,
   input  logic [`DEC_INSN_W-1:0] push_ins,
   input  logic [`DEC_PC_W-1:0]   push_pc,
   output logic                   push_ready,
   fetch_if.queue                 fq
);

   localparam logic [`DEC_FQ_AW:0] FULL = `DEC_FQ_DEPTH;

   logic [`DEC_INSN_W-1:0] ins_mem [`DEC_FQ_DEPTH];
   logic [`DEC_PC_W-1:0]   pc_mem  [`DEC_FQ_DEPTH];
   logic [`DEC_FQ_AW-1:0]  head;
   logic [`DEC_FQ_AW-1:0]  tail;
   logic [`DEC_FQ_AW:0]    count;
   logic                   push_en;
   logic [`DEC_FQ_AW:0]    pop_n;

   assign push_ready = (count != FULL);
   assign push_en    = push_valid & push_ready;

   // Pop count widened to the occupancy width
   assign pop_n = {{(`DEC_FQ_AW - `DEC_P_ISSUE_WIDTH){1'b0}}, fq.pop_cnt};

   // Lane i shows the entry i places behind head
   for (genvar i = 0; i < `DEC_ISSUE_WIDTH; i++)
   begin : gen_lane
      localparam logic [`DEC_FQ_AW-1:0] OFFSET = i;
      logic [`DEC_FQ_AW-1:0] rd_ptr;

      assign rd_ptr      = head + OFFSET;
      assign fq.valid[i] = (count > i);
      assign fq.ins[i]   = ins_mem[rd_ptr];
      assign fq.pc[i]    = pc_mem[rd_ptr];
   end

   // Pointers and occupancy, flush wins over any push in the same cycle
   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         if (push_en)
         begin
            tail <= tail + 1'b1;
         end
         head  <= head + pop_n[`DEC_FQ_AW-1:0];
         count <= count + {{`DEC_FQ_AW{1'b0}}, push_en} - pop_n;
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (push_en)
      begin
         ins_mem[tail] <= push_ins;
         pc_mem[tail]  <= push_pc;
      end
   end

endmodule

/* source/id_dec.sv */
// Single-lane instruction decoder, purely combinational
// The parent qualifies irq so only lane 0 can be replaced by the interrupt op

`timescale 1ns/100ps

`include "decode_defs.svh"

module id_dec
   import decode_pkg::*;
(
   input  logic                   valid,
   input  logic [`DEC_INSN_W-1:0] ins,
   input  logic                   irq,
   output uop_t                   uop
);

   logic [5:0]             opc;
   logic [5:0]             fn;
   logic [`DEC_LRF_AW-1:0] f_rd;
   logic [`DEC_LRF_AW-1:0] f_rs1;
   logic [`DEC_LRF_AW-1:0] f_rs2;
   logic [`DEC_DW-1:0]     imm_sext;
   logic [`DEC_DW-1:0]     imm_zext;

   uop_op_t                op;
   logic [`DEC_DW-1:0]     imm;
   logic [`DEC_LRF_AW-1:0] lrs2;
   logic                   rs1_re;
   logic                   rs2_re;
   logic                   rd_we;

   // Field extraction
   assign opc   = ins[31:26];
   assign f_rd  = ins[25:21];
   assign f_rs1 = ins[20:16];
   assign f_rs2 = ins[15:11];
   assign fn    = ins[5:0];

   assign imm_sext = {{(`DEC_DW - 16){ins[15]}}, ins[15:0]};
   assign imm_zext = {{(`DEC_DW - 16){1'b0}}, ins[15:0]};

   always_comb
   begin
      op     = OP_ILLEGAL;
      imm    = '0;
      lrs2   = f_rs2;
      rs1_re = 1'b0;
      rs2_re = 1'b0;
      rd_we  = 1'b0;
      case (opc)
         `DEC_OPC_ALU:
         begin
            rs1_re = 1'b1;
            rs2_re = 1'b1;
            rd_we  = 1'b1;
            case (fn)
               `DEC_FN_ADD: op = OP_ADD;
               `DEC_FN_SUB: op = OP_SUB;
               `DEC_FN_AND: op = OP_AND;
               `DEC_FN_OR:  op = OP_OR;
               `DEC_FN_XOR: op = OP_XOR;
               default:
               begin
                  // Unknown function code touches no registers
                  rs1_re = 1'b0;
                  rs2_re = 1'b0;
                  rd_we  = 1'b0;
               end
            endcase
         end
         `DEC_OPC_ADDI, `DEC_OPC_ANDI, `DEC_OPC_LW:
         begin
            op     = (opc == `DEC_OPC_ADDI) ? OP_ADD :
                     (opc == `DEC_OPC_ANDI) ? OP_AND : OP_LOAD;
            imm    = (opc == `DEC_OPC_ANDI) ? imm_zext : imm_sext;
            rs1_re = 1'b1;
            rd_we  = 1'b1;
         end
         `DEC_OPC_SW, `DEC_OPC_BEQ:
         begin
            // Second source sits in the rd field for stores and branches
            op     = (opc == `DEC_OPC_SW) ? OP_STORE : OP_BEQ;
            imm    = imm_sext;
            lrs2   = f_rd;
            rs1_re = 1'b1;
            rs2_re = 1'b1;
         end
         `DEC_OPC_JAL:
         begin
            op    = OP_JAL;
            imm   = imm_sext;
            rd_we = 1'b1;
         end
         default:
         begin
            op = OP_ILLEGAL;
         end
      endcase
   end

   // Interrupt replaces the op and drops all register traffic
   assign uop.op      = irq ? OP_IRQ : op;
   assign uop.imm     = imm;
   assign uop.lrs1    = f_rs1;
   assign uop.lrs1_re = valid & ~irq & rs1_re;
   assign uop.lrs2    = lrs2;
   assign uop.lrs2_re = valid & ~irq & rs2_re;
   assign uop.lrd     = f_rd;
   // r0 is never written
   assign uop.lrd_we  = valid & ~irq & rd_we & (f_rd != '0);

endmodule

/* source/id.sv */
// Decode stage between the fetch queue and rename
// Decodes every lane in parallel and registers the group once rename can take it

`timescale 1ns/100ps

`include "decode_defs.svh"

module id
   import decode_pkg::*;
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                flush,
   input  logic                                rn_stall_req,
   input  logic                                irq_async,
   fetch_if.dec                                fe,
   output logic [`DEC_ISSUE_WIDTH-1:0]         rn_valid,
   output uop_t [`DEC_ISSUE_WIDTH-1:0]         rn_uop,
   output logic [`DEC_ISSUE_WIDTH-1:0][`DEC_PC_W-1:0] rn_pc
);

   localparam int IW = `DEC_ISSUE_WIDTH;

   logic                          p_ce;
   logic [IW-1:0]                 irq_lane;
   uop_t [IW-1:0]                 dec_uop;
   logic [`DEC_P_ISSUE_WIDTH:0]   pop_cnt;

   // Pipeline advances whenever rename is not stalling
   assign p_ce = ~rn_stall_req;

   // Only the oldest lane takes the interrupt
   assign irq_lane = {{(IW - 1){1'b0}}, irq_async};

   for (genvar i = 0; i < IW; i++)
   begin : gen_dec
      id_dec id_dec_i
      (
         .valid (fe.valid[i]),
         .ins   (fe.ins[i]),
         .irq   (irq_lane[i]),
         .uop   (dec_uop[i])
      );
   end

   // Every valid lane is consumed when the stage advances
   always_comb
   begin
      pop_cnt = '0;
      for (int i = 0; i < IW; i++)
      begin
         pop_cnt = pop_cnt + {{`DEC_P_ISSUE_WIDTH{1'b0}}, fe.valid[i] & p_ce};
      end
   end

   assign fe.pop_cnt = pop_cnt;

   always_ff @(posedge clk)
   begin
      if (rst || flush)
      begin
         rn_valid <= '0;
      end
      else if (p_ce)
      begin
         rn_valid <= fe.valid;
      end
   end

   // Payload holds under stall
   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         rn_uop <= dec_uop;
         rn_pc  <= fe.pc;
      end
   end

endmodule

/* source/decode_top.sv */
// Decode front end top level with the fetch queue and the decode stage
// The rename side sees one plain port per micro-op field, packed per lane

`timescale 1ns/100ps

`include "decode_defs.svh"

module decode_top
   import decode_pkg::*;
(
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          flush,
   input  logic                                          rn_stall_req,
   input  logic                                          irq_async,
   input  logic                                          push_valid,
   input  logic [`DEC_INSN_W-1:0]                        push_ins,
   input  logic [`DEC_PC_W-1:0]                          push_pc,
   output logic                                          push_ready,
   output logic [`DEC_ISSUE_WIDTH-1:0]                   rn_valid,
   output uop_op_t [`DEC_ISSUE_WIDTH-1:0]                rn_op,
   output logic [`DEC_ISSUE_WIDTH-1:0][`DEC_DW-1:0]      rn_imm,
   output logic [`DEC_ISSUE_WIDTH-1:0][`DEC_LRF_AW-1:0]  rn_lrs1,
   output logic [`DEC_ISSUE_WIDTH-1:0]                   rn_lrs1_re,
   output logic [`DEC_ISSUE_WIDTH-1:0][`DEC_LRF_AW-1:0]  rn_lrs2,
   output logic [`DEC_ISSUE_WIDTH-1:0]                   rn_lrs2_re,
   output logic [`DEC_ISSUE_WIDTH-1:0][`DEC_LRF_AW-1:0]  rn_lrd,
   output logic [`DEC_ISSUE_WIDTH-1:0]                   rn_lrd_we,
   output logic [`DEC_ISSUE_WIDTH-1:0][`DEC_PC_W-1:0]    rn_pc
);

   uop_t [`DEC_ISSUE_WIDTH-1:0] rn_uop;

   fetch_if fq_if ();

   fetch_queue fetch_queue_i
   (
      .clk        (clk),
      .rst        (rst),
      .flush      (flush),
      .push_valid (push_valid),
      .push_ins   (push_ins),
      .push_pc    (push_pc),
      .push_ready (push_ready),
      .fq         (fq_if)
   );

   id id_i
   (
      .clk          (clk),
      .rst          (rst),
      .flush        (flush),
      .rn_stall_req (rn_stall_req),
      .irq_async    (irq_async),
      .fe           (fq_if),
      .rn_valid     (rn_valid),
      .rn_uop       (rn_uop),
      .rn_pc        (rn_pc)
   );

   // Split each lane's micro-op into its fields
   for (genvar i = 0; i < `DEC_ISSUE_WIDTH; i++)
   begin : gen_unpack
      assign rn_op[i]      = rn_uop[i].op;
      assign rn_imm[i]     = rn_uop[i].imm;
      assign rn_lrs1[i]    = rn_uop[i].lrs1;
      assign rn_lrs1_re[i] = rn_uop[i].lrs1_re;
      assign rn_lrs2[i]    = rn_uop[i].lrs2;
      assign rn_lrs2_re[i] = rn_uop[i].lrs2_re;
      assign rn_lrd[i]     = rn_uop[i].lrd;
      assign rn_lrd_we[i]  = rn_uop[i].lrd_we;
   end

endmodule

/* sim/tb_clock.sv */
// Free-running clock for the decode testbench
// PERIOD is in ns, the first rising edge comes half a period in

`timescale 1ns/100ps

module tb_clock
#(
   parameter real PERIOD = 40.0
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

endmodule

/* sim/tb_decode.sv */
// Testbench for the decode front end with pushes, stalls, flushes and interrupts
// Every retired lane is checked against a reference decoder

`timescale 1ns/100ps

`include "decode_defs.svh"

module tb_decode
   import decode_pkg::*;
;

   localparam int IW          = `DEC_ISSUE_WIDTH;
   localparam int ENT_W       = `DEC_INSN_W + `DEC_PC_W;
   localparam int OUT_W       = IW * ($bits(uop_t) + 1 + `DEC_PC_W);
   localparam int FILL_N      = 9;
   localparam int BURST_N     = 40;
   localparam int RAND_N      = 300;
   localparam int FLUSH_N     = 5;
   localparam int POST_N      = 4;
   localparam int PUSH_TOTAL  = FILL_N + BURST_N + RAND_N + FLUSH_N + 1 + POST_N;
   localparam int CYCLE_LIMIT = 4 * PUSH_TOTAL + 200;

   logic                             clk;
   logic                             rst;
   logic                             flush;
   logic                             rn_stall_req;
   logic                             irq_async;
   logic                             push_valid;
   logic [`DEC_INSN_W-1:0]           push_ins;
   logic [`DEC_PC_W-1:0]             push_pc;
   logic                             push_ready;
   logic [IW-1:0]                    rn_valid;
   uop_op_t [IW-1:0]                 rn_op;
   logic [IW-1:0][`DEC_DW-1:0]       rn_imm;
   logic [IW-1:0][`DEC_LRF_AW-1:0]   rn_lrs1;
   logic [IW-1:0]                    rn_lrs1_re;
   logic [IW-1:0][`DEC_LRF_AW-1:0]   rn_lrs2;
   logic [IW-1:0]                    rn_lrs2_re;
   logic [IW-1:0][`DEC_LRF_AW-1:0]   rn_lrd;
   logic [IW-1:0]                    rn_lrd_we;
   logic [IW-1:0][`DEC_PC_W-1:0]     rn_pc;

   // Expected entries in push order as {instruction, pc}
   logic [ENT_W-1:0] exp_q [$];
   logic [31:0]      lfsr = 32'hb788;
   logic [31:0]      next_pc = 32'h1000;
   logic [OUT_W-1:0] out_now;
   logic [OUT_W-1:0] prev_out;
   logic             was_rst = 1'b1;
   logic             was_flush = 1'b0;
   logic             was_stall = 1'b0;
   logic             was_irq = 1'b0;
   logic [IW-1:0]    exp_mask;
   int               n_take = 0;
   int               cycles = 0;
   int               mism_err = 0;
   int               other_err = 0;
   int               retired = 0;

   tb_clock #(.PERIOD(40.0)) tb_clock_i (.clk(clk));

   decode_top decode_top_i
   (
      .clk          (clk),
      .rst          (rst),
      .flush        (flush),
      .rn_stall_req (rn_stall_req),
      .irq_async    (irq_async),
      .push_valid   (push_valid),
      .push_ins     (push_ins),
      .push_pc      (push_pc),
      .push_ready   (push_ready),
      .rn_valid     (rn_valid),
      .rn_op        (rn_op),
      .rn_imm       (rn_imm),
      .rn_lrs1      (rn_lrs1),
      .rn_lrs1_re   (rn_lrs1_re),
      .rn_lrs2      (rn_lrs2),
      .rn_lrs2_re   (rn_lrs2_re),
      .rn_lrd       (rn_lrd),
      .rn_lrd_we    (rn_lrd_we),
      .rn_pc        (rn_pc)
   );

   // All rename-side outputs in one vector for the hold check
   assign out_now = {rn_valid, rn_op, rn_imm, rn_lrs1, rn_lrs1_re, rn_lrs2, rn_lrs2_re,
                     rn_lrd, rn_lrd_we, rn_pc};

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Random instruction over all opcodes plus two illegal ones and fn codes 0 to 7
   function automatic logic [`DEC_INSN_W-1:0] make_insn();
      logic [5:0]  opc;
      logic [4:0]  rd;
      logic [20:0] rest;
      logic [31:0] r;
      case (take_bits(4) % 9)
         0:       opc = `DEC_OPC_ALU;
         1:       opc = `DEC_OPC_ADDI;
         2:       opc = `DEC_OPC_ANDI;
         3:       opc = `DEC_OPC_LW;
         4:       opc = `DEC_OPC_SW;
         5:       opc = `DEC_OPC_BEQ;
         6:       opc = `DEC_OPC_JAL;
         7:       opc = 6'h03;
         default: opc = 6'h3f;
      endcase
      // r0 as destination about a quarter of the time
      rd = 5'd0;
      if (take_bits(2) != 0)
      begin
         r  = take_bits(5);
         rd = r[4:0];
      end
      r    = take_bits(21);
      rest = r[20:0];
      if (opc == `DEC_OPC_ALU)
      begin
         r         = take_bits(3);
         rest[5:0] = {3'b000, r[2:0]};
      end
      return {opc, rd, rest};
   endfunction

   // Reference decode straight from the instruction set rules
   function automatic uop_t ref_decode(input logic [`DEC_INSN_W-1:0] ins, input logic irq);
      uop_t        u;
      logic [31:0] sext;
      sext = {{16{ins[15]}}, ins[15:0]};
      u      = '0;
      u.op   = OP_ILLEGAL;
      u.lrd  = ins[25:21];
      u.lrs1 = ins[20:16];
      u.lrs2 = ins[15:11];
      case (ins[31:26])
         `DEC_OPC_ALU:
         begin
            case (ins[5:0])
               `DEC_FN_ADD: u.op = OP_ADD;
               `DEC_FN_SUB: u.op = OP_SUB;
               `DEC_FN_AND: u.op = OP_AND;
               `DEC_FN_OR:  u.op = OP_OR;
               `DEC_FN_XOR: u.op = OP_XOR;
               default:     u.op = OP_ILLEGAL;
            endcase
            u.lrs1_re = (u.op != OP_ILLEGAL);
            u.lrs2_re = (u.op != OP_ILLEGAL);
            u.lrd_we  = (u.op != OP_ILLEGAL);
         end
         `DEC_OPC_ADDI: u = '{OP_ADD, sext, u.lrs1, 1'b1, u.lrs2, 1'b0, u.lrd, 1'b1};
         `DEC_OPC_ANDI: u = '{OP_AND, {16'h0, ins[15:0]}, u.lrs1, 1'b1, u.lrs2, 1'b0, u.lrd, 1'b1};
         `DEC_OPC_LW:   u = '{OP_LOAD, sext, u.lrs1, 1'b1, u.lrs2, 1'b0, u.lrd, 1'b1};
         `DEC_OPC_SW:   u = '{OP_STORE, sext, u.lrs1, 1'b1, ins[25:21], 1'b1, u.lrd, 1'b0};
         `DEC_OPC_BEQ:  u = '{OP_BEQ, sext, u.lrs1, 1'b1, ins[25:21], 1'b1, u.lrd, 1'b0};
         `DEC_OPC_JAL:  u = '{OP_JAL, sext, u.lrs1, 1'b0, u.lrs2, 1'b0, u.lrd, 1'b1};
         default:       u.op = OP_ILLEGAL;
      endcase
      if (u.lrd == '0)
      begin
         u.lrd_we = 1'b0;
      end
      if (irq)
      begin
         u.op      = OP_IRQ;
         u.lrs1_re = 1'b0;
         u.lrs2_re = 1'b0;
         u.lrd_we  = 1'b0;
      end
      return u;
   endfunction

   task automatic report_mismatch(input string what, input int ln,
                                  input logic [63:0] got, input logic [63:0] exp);
      mism_err++;
      $display("mismatch at %0t ns: lane %0d %s got %0h expected %0h", $time, ln, what, got, exp);
   endtask

   // Checks one retired lane against the reference decode
   // Register fields are compared only where enabled
   task automatic check_lane(input int ln, input logic [ENT_W-1:0] e, input logic irq);
      uop_t x;
      x = ref_decode(e[ENT_W-1:`DEC_PC_W], irq);
      assert (rn_op[ln] == x.op) else report_mismatch("op", ln, rn_op[ln], x.op);
      assert (rn_lrs1_re[ln] == x.lrs1_re)
         else report_mismatch("lrs1_re", ln, rn_lrs1_re[ln], x.lrs1_re);
      assert (rn_lrs2_re[ln] == x.lrs2_re)
         else report_mismatch("lrs2_re", ln, rn_lrs2_re[ln], x.lrs2_re);
      assert (rn_lrd_we[ln] == x.lrd_we)
         else report_mismatch("lrd_we", ln, rn_lrd_we[ln], x.lrd_we);
      assert (x.op == OP_ILLEGAL || x.op == OP_IRQ || rn_imm[ln] == x.imm)
         else report_mismatch("imm", ln, rn_imm[ln], x.imm);
      assert (!x.lrs1_re || rn_lrs1[ln] == x.lrs1)
         else report_mismatch("lrs1", ln, rn_lrs1[ln], x.lrs1);
      assert (!x.lrs2_re || rn_lrs2[ln] == x.lrs2)
         else report_mismatch("lrs2", ln, rn_lrs2[ln], x.lrs2);
      assert (!x.lrd_we || rn_lrd[ln] == x.lrd)
         else report_mismatch("lrd", ln, rn_lrd[ln], x.lrd);
      assert (rn_pc[ln] == e[`DEC_PC_W-1:0])
         else report_mismatch("pc", ln, rn_pc[ln], e[`DEC_PC_W-1:0]);
      retired++;
   endtask

   task automatic finish_run();
      $display("errors: %0d mismatch, %0d other, %0d retired", mism_err, other_err, retired);
      if (mism_err == 0 && other_err == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   endtask

   // Drives one cycle of inputs 2 ns after the rising edge
   task automatic drive_cycle(input logic pv, input logic st, input logic iq, input logic fl);
      @(posedge clk);
      #2;
      push_valid   = pv;
      rn_stall_req = st;
      irq_async    = iq;
      flush        = fl;
      if (pv)
      begin
         push_ins = make_insn();
         push_pc  = next_pc;
         next_pc  = next_pc + 4;
      end
   endtask

   // Model of queue occupancy and group take at each edge
   always @(posedge clk)
   begin
      was_rst   = rst;
      was_flush = flush;
      was_stall = rn_stall_req;
      was_irq   = irq_async;
      n_take    = 0;
      if (rst || flush)
      begin
         exp_q.delete();
      end
      else
      begin
         if (!rn_stall_req)
         begin
            n_take = (exp_q.size() > 1) ? 2 : exp_q.size();
         end
         if (push_valid && exp_q.size() < `DEC_FQ_DEPTH)
         begin
            exp_q.push_back({push_ins, push_pc});
         end
      end
      cycles++;
      if (cycles >= CYCLE_LIMIT)
      begin
         other_err++;
         $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
         finish_run();
      end
   end

   // Outputs are settled mid-cycle
   always @(negedge clk)
   begin
      if (was_rst || was_flush)
      begin
         assert (rn_valid == '0) else
         begin
            other_err++;
            $display("rn_valid still set at %0t ns after reset or flush", $time);
         end
      end
      else if (was_stall)
      begin
         assert (out_now === prev_out) else
         begin
            mism_err++;
            $display("mismatch at %0t ns: rename outputs changed during stall", $time);
         end
      end
      else
      begin
         exp_mask = (n_take == 2) ? 2'b11 : (n_take == 1) ? 2'b01 : 2'b00;
         assert (rn_valid == exp_mask) else
         begin
            other_err++;
            $display("unexpected rn_valid %b at %0t ns, expected %b", rn_valid, $time, exp_mask);
         end
         for (int i = 0; i < n_take; i++)
         begin
            check_lane(i, exp_q.pop_front(), (i == 0) && was_irq);
         end
      end
      assert (push_ready == (exp_q.size() != `DEC_FQ_DEPTH))
         else report_mismatch("push_ready", 0, push_ready, exp_q.size() != `DEC_FQ_DEPTH);
      prev_out = out_now;
   end

   initial
   begin
      logic pv;
      logic st;
      logic iq;
      rst          = 1'b1;
      flush        = 1'b0;
      rn_stall_req = 1'b0;
      irq_async    = 1'b0;
      push_valid   = 1'b0;
      push_ins     = '0;
      push_pc      = '0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      // Rename stalled so the ninth push meets a full queue
      for (int k = 0; k < FILL_N; k++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      for (int k = 0; k < BURST_N; k++)
         drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
      for (int k = 0; k < RAND_N; k++)
      begin
         pv = (take_bits(2) != 0);
         st = (take_bits(2) == 0);
         iq = (take_bits(3) == 0);
         drive_cycle(pv, st, iq, 1'b0);
      end
      // Partly filled queue flushed with a push in the same cycle
      for (int k = 0; k < FLUSH_N; k++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      drive_cycle(1'b1, 1'b0, 1'b0, 1'b1);
      for (int k = 0; k < POST_N; k++)
         drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
      while (exp_q.size() != 0)
         drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      finish_run();
   end

endmodule

/* tb.f */
+incdir+include
source/decode_pkg.sv
source/fetch_if.sv
source/fetch_queue.sv
source/id_dec.sv
source/id.sv
source/decode_top.sv
sim/tb_clock.sv
sim/tb_decode.sv
